//--- sources.f
+incdir+.
i2c_pkg.sv
i2c_reg_file.sv
i2c_scl_gen.sv
i2c_byte_engine.sv
i2c_master.sv
tb_i2c_slave.sv
tb_i2c_master.sv

//--- i2c_golden.txt
# dir(0 write, 1 read) addr nby bytes_moved tdr slave_rdata exp_cfg exp_rdr
# The slave answers at address 2a; bytes_moved is 0 when the address is NACKed.
0 2a 1 1 000000a5 00000000 00000003 00000000
1 2a 4 4 00000000 12345678 0000000c 12345678
1 2a 0 1 00000000 0000009c 0000000c 0000009c
1 31 2 0 00000000 0000beef 0000001c 0000009c
0 2a 6 4 deadbeef 00000000 00000003 0000009c
0 55 2 0 00001234 00000000 00000013 0000009c
1 2a 2 2 00000000 0000c3a5 0000000c 0000c3a5
0 2a 3 3 00112233 00000000 00000003 0000c3a5

//--- tb_i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_settings.svh"

module tb_i2c_master import i2c_pkg::*; ();

	logic        clk_i;
	logic        rst_i;
	host_req_t   host_req;
	word_t       rdata;
	wire         scl;
	wire         sda;
	logic        exp_rd;
	logic [6:0]  exp_addr;
	logic [2:0]  exp_n;
	logic [31:0] wr_word, rd_word;
	logic        slave_err;
	logic [7:0]  lfsr_q;
	int          num_lines;

	pullup (sda);

	i2c_master dut0 (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.host_req_i (host_req),
		.rdata_o    (rdata),
		.scl_o      (scl),
		.sda_io     (sda)
	);

	tb_i2c_slave #(.OWN_ADDR(7'h2a)) slave0 (
		.scl_i      (scl),
		.sda_io     (sda),
		.exp_rd_i   (exp_rd),
		.exp_addr_i (exp_addr),
		.exp_n_i    (exp_n),
		.wr_word_i  (wr_word),
		.rd_word_i  (rd_word),
		.error_o    (slave_err)
	);

	always #10 clk_i = ~clk_i;

	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v      = (v << 1) | lfsr_q[0];
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic host_write(input reg_addr_t addr, input word_t data, input byte_en_t be);
		@(posedge clk_i);
		host_req.write <= 1'b1;
		host_req.be    <= be;
		host_req.addr  <= addr;
		host_req.wdata <= data;
		@(posedge clk_i);
		host_req.write <= 1'b0;
	endtask

	task automatic host_read(input reg_addr_t addr, output word_t data);
		@(posedge clk_i);
		host_req.write <= 1'b0;
		host_req.addr  <= addr;
		@(posedge clk_i);
		@(negedge clk_i); // rdata settles one edge after the address.
		data = rdata;
	endtask

	function automatic bit is_data_line(input logic [8*256-1:0] buf_l, input int len);
		if (len < 2) return 0;
		return buf_l[8*len-1 -: 8] != "#";
	endfunction

	task automatic run_line(input logic [8*256-1:0] buf_l);
		int    dir, addr, nby, n, cfg_exp, gap, cnt;
		word_t tdr, rdw, rdr_exp, v;
		cnt = $sscanf(buf_l, "%h %h %h %h %h %h %h %h", dir, addr, nby, n, tdr, rdw, cfg_exp,
			rdr_exp);
		if (cnt != 8) begin
			$display("golden file line could not be parsed");
			$display("Errors found");
			$fatal(1);
		end
		exp_rd   = dir[0];
		exp_addr = addr[6:0];
		exp_n    = n[2:0];
		wr_word  = tdr;
		rd_word  = rdw;
		take_bits(4, gap);
		repeat (gap) @(posedge clk_i);
		host_write(`I2C_NBY, nby, 4'hf);
		host_write(`I2C_ADR, addr, 4'hf);
		host_write(`I2C_TDR, tdr, 4'hf);
		host_write(`I2C_CFG, dir[0] ? 32'h4 : 32'h1, 4'hf);
		do begin
			host_read(`I2C_CFG, v);
		end while (!v[dir[0] ? CFG_RD_DONE : CFG_WR_DONE]);
		check_value("cfg", cfg_exp, v);
		host_read(`I2C_RDR, v);
		check_value("rdr", rdr_exp, v);
		wait (sda === 1'b1); // Let the STOP condition finish.
		@(posedge clk_i); // The slave model counts the bytes on the STOP edge.
	endtask

	always @(posedge slave_err) begin
		$display("the I2C slave model saw a transfer that differs from the golden file");
		$display("Errors found");
		$fatal(1);
	end

	initial begin
		wait (num_lines > 0);
		#((num_lines + 1) * 50 * 250 * 20);
		$display("watchdog expired before all transactions completed");
		$display("Errors found");
		$fatal(1);
	end

	initial begin
		logic [8*256-1:0] line_buf;
		int               fd, len;
		word_t            v;
		clk_i     = 1'b0;
		rst_i     = 1'b1;
		host_req  = '0;
		exp_rd    = 1'b0;
		exp_addr  = '0;
		exp_n     = '0;
		wr_word   = '0;
		rd_word   = '0;
		lfsr_q    = 8'd58;
		num_lines = 0;

		fd = $fopen("i2c_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open the golden file");
			$display("Errors found");
			$fatal(1);
		end
		len = $fgets(line_buf, fd);
		while (len > 0) begin
			if (is_data_line(line_buf, len)) num_lines++;
			len = $fgets(line_buf, fd);
		end
		$fclose(fd);
		if (num_lines == 0) begin
			$display("golden file holds no transactions");
			$display("Errors found");
			$fatal(1);
		end

		repeat (16) @(posedge clk_i);
		rst_i <= 1'b0;

		host_read(`I2C_CFG, v);
		check_value("cfg", 32'h0, v);
		host_read(`I2C_NBY, v);
		check_value("nby", 32'h0, v);
		host_read(`I2C_RDR, v);
		check_value("rdr", 32'h0, v);
		check_value("scl", 32'h1, {31'b0, scl});
		check_value("sda", 32'h1, {31'b0, sda});

		host_write(`I2C_TDR, 32'h11223344, 4'hf);
		host_write(`I2C_TDR, 32'haabbccdd, 4'b0101);
		host_read(`I2C_TDR, v);
		check_value("tdr", 32'h11bb33dd, v);

		fd  = $fopen("i2c_golden.txt", "r");
		len = $fgets(line_buf, fd);
		while (len > 0) begin
			if (is_data_line(line_buf, len)) run_line(line_buf);
			len = $fgets(line_buf, fd);
		end
		$fclose(fd);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_i2c_slave.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_slave #(
	parameter logic [6:0] OWN_ADDR = 7'h2a
) (
	input  wire         scl_i,
	inout  wire         sda_io,
	input  logic        exp_rd_i,
	input  logic [6:0]  exp_addr_i,
	input  logic [2:0]  exp_n_i,
	input  logic [31:0] wr_word_i,
	input  logic [31:0] rd_word_i,
	output logic        error_o
);

	logic        active, in_addr, matched, rw, sending, ack_due, drive_low;
	logic [3:0]  bit_cnt;
	logic [2:0]  byte_cnt;
	logic [7:0]  shift_q;
	logic [31:0] word_tmp;
	logic        exp_rd_q;
	logic [6:0]  exp_addr_q;
	logic [2:0]  exp_n_q;
	logic [31:0] wr_word_q, rd_word_q;

	initial begin
		active    = 1'b0;
		drive_low = 1'b0;
		error_o   = 1'b0;
	end

	assign sda_io = drive_low ? 1'b0 : 1'bz;

	task automatic report_mismatch(input string msg);
		$display("slave model at %0t: %s", $time, msg);
		error_o = 1'b1;
	endtask

	// START: the expected transfer is latched here.
	always @(negedge sda_io) begin
		if (scl_i === 1'b1) begin
			active     = 1'b1;
			in_addr    = 1'b1;
			matched    = 1'b0;
			rw         = 1'b0;
			sending    = 1'b0;
			ack_due    = 1'b0;
			bit_cnt    = 4'd0;
			byte_cnt   = 3'd0;
			exp_rd_q   = exp_rd_i;
			exp_addr_q = exp_addr_i;
			exp_n_q    = exp_n_i;
			wr_word_q  = wr_word_i;
			rd_word_q  = rd_word_i;
		end
	end

	always @(posedge sda_io) begin
		if (scl_i === 1'b1 && active) begin
			active = 1'b0; // STOP.
			if (byte_cnt != exp_n_q) report_mismatch("wrong number of data bytes before STOP");
		end
	end

	always @(posedge scl_i) begin
		if (active && bit_cnt < 8) begin
			shift_q = {shift_q[6:0], (sda_io === 1'b0) ? 1'b0 : 1'b1};
			if (bit_cnt == 7 && in_addr) begin
				matched = (shift_q[7:1] == OWN_ADDR);
				rw      = shift_q[0];
				ack_due = matched;
				if (shift_q[7:1] != exp_addr_q) report_mismatch("address differs from golden line");
				if (rw != exp_rd_q) report_mismatch("R/W bit differs from golden line");
			end else if (bit_cnt == 7 && !rw) begin
				word_tmp = wr_word_q >> (8 * (exp_n_q - 1 - byte_cnt));
				if (byte_cnt >= exp_n_q || shift_q != word_tmp[7:0]) begin
					report_mismatch("write data byte differs from golden line");
				end
				byte_cnt = byte_cnt + 1'b1;
				ack_due  = 1'b1;
			end
			bit_cnt = bit_cnt + 1'b1;
		end else if (active) begin
			// Ninth clock of a byte.
			if (in_addr) begin
				sending = matched && rw;
			end else if (rw) begin
				if ((sda_io === 1'b0) != (byte_cnt + 1 < exp_n_q)) begin
					report_mismatch("master ACK or NACK wrong after read byte");
				end
				byte_cnt = byte_cnt + 1'b1;
				sending  = (sda_io === 1'b0);
			end
			in_addr = 1'b0;
			ack_due = 1'b0;
			bit_cnt = 4'd0;
		end
	end

	always @(negedge scl_i) begin
		if (active) begin
			if (bit_cnt == 8) begin
				drive_low = ack_due;
			end else if (sending && byte_cnt < exp_n_q) begin
				word_tmp  = rd_word_q >> (8 * (exp_n_q - 1 - byte_cnt));
				drive_low = !word_tmp[7 - bit_cnt];
			end else begin
				drive_low = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_settings.svh"

module i2c_master import i2c_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  host_req_t host_req_i,
	output word_t     rdata_o,
	output logic      scl_o,
	inout  wire       sda_io
);

	scl_phase_t phase;
	eng_rd_t    eng_rd;
	word_t      eng_rdata;
	eng_wr_t    eng_wr;
	logic       scl_hold;
	logic       busy;

	i2c_reg_file u_reg_file (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.host_i      (host_req_i),
		.rdata_o     (rdata_o),
		.eng_rd_i    (eng_rd),
		.eng_rdata_o (eng_rdata),
		.eng_wr_i    (eng_wr)
	);

	i2c_scl_gen u_scl_gen (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.phase_o (phase)
	);

	i2c_byte_engine u_engine (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.phase_i     (phase),
		.eng_rd_o    (eng_rd),
		.eng_rdata_i (eng_rdata),
		.eng_wr_o    (eng_wr),
		.scl_hold_o  (scl_hold),
		.sda_io      (sda_io)
	);

	assign scl_o = phase.level | scl_hold;

	// The engine only watches CFG while idle or finishing with STOP.
	assign busy = (eng_rd != `I2C_CFG);

	a_no_write_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		busy && host_req_i.write |->
		!(host_req_i.addr inside {`I2C_NBY, `I2C_ADR, `I2C_TDR}))
		else $error("host wrote %0h during a transaction", host_req_i.addr);

endmodule

`default_nettype wire

//--- i2c_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_settings.svh"

module i2c_byte_engine import i2c_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  scl_phase_t phase_i,
	output eng_rd_t    eng_rd_o,
	input  word_t      eng_rdata_i,
	output eng_wr_t    eng_wr_o,
	output logic       scl_hold_o,
	inout  wire        sda_io
);

	i2c_state_e state_q, state_d;
	bit_idx_t   bit_q, bit_d;
	byte_cnt_t  cnt_q, cnt_d;
	byte_cnt_t  nby_cnt;
	logic       rd_q, rd_d;     // Current transfer reads from the slave.
	logic       nack_q, nack_d;
	logic       sda_q;          // Low pulls SDA down, high releases it.
	logic       sda_nxt;
	logic       wr_pend, rd_pend;
	logic [7:0] addr_byte;
	logic [4:0] data_pos;

	// Pending flags are valid in IDLE, where CFG is selected.
	assign wr_pend   = eng_rdata_i[CFG_WR_GO] ^ eng_rdata_i[CFG_WR_DONE];
	assign rd_pend   = eng_rdata_i[CFG_RD_GO] ^ eng_rdata_i[CFG_RD_DONE];
	assign addr_byte = {eng_rdata_i[6:0], rd_q};
	assign data_pos  = {cnt_q[1:0], bit_q}; // Highest byte goes out first.

	assign scl_hold_o = (state_q == IDLE) || (state_q == START);
	assign sda_io     = sda_q ? 1'bz : 1'b0;

	// NBY of 0 and 1 both mean one byte, large values are clamped.
	always_comb begin
		if (eng_rdata_i >= `I2C_MAX_BYTES) begin
			nby_cnt = byte_cnt_t'(`I2C_MAX_BYTES - 1);
		end else if (eng_rdata_i == '0) begin
			nby_cnt = '0;
		end else begin
			nby_cnt = byte_cnt_t'(eng_rdata_i - 1);
		end
	end

	always_comb begin
		unique case (state_q)
			START:       eng_rd_o = `I2C_NBY;
			ADDR, ACK0:  eng_rd_o = `I2C_ADR;
			WDATA:       eng_rd_o = `I2C_TDR;
			RDATA, ACK1: eng_rd_o = `I2C_RDR;
			default:     eng_rd_o = `I2C_CFG;
		endcase
	end

	// Next state, counters and register writes. Everything moves on a rise strobe.
	always_comb begin
		state_d       = state_q;
		bit_d         = bit_q;
		cnt_d         = cnt_q;
		rd_d          = rd_q;
		nack_d        = nack_q;
		eng_wr_o.en   = 1'b0;
		eng_wr_o.sel  = `I2C_RDR;
		eng_wr_o.data = eng_rdata_i;

		if (phase_i.rise) begin
			unique case (state_q)
				IDLE: begin
					if (wr_pend || rd_pend) begin
						state_d = START;
						rd_d    = !wr_pend; // Write wins when both are pending.
					end
				end
				START: begin
					cnt_d   = nby_cnt;
					bit_d   = 3'd7;
					nack_d  = 1'b0;
					state_d = ADDR;
				end
				ADDR: begin
					if (bit_q == 3'd0) state_d = ACK0;
					else bit_d = bit_q - 1'b1;
				end
				ACK0: begin
					bit_d = 3'd7;
					if (sda_io) begin
						nack_d  = 1'b1;
						state_d = STOP;
					end else if (rd_q) begin
						eng_wr_o.en   = 1'b1; // Clear RDR before the first byte arrives.
						eng_wr_o.data = '0;
						state_d       = RDATA;
					end else begin
						state_d = WDATA;
					end
				end
				WDATA: begin
					if (bit_q == 3'd0) state_d = ACK1;
					else bit_d = bit_q - 1'b1;
				end
				RDATA: begin
					eng_wr_o.en             = 1'b1;
					eng_wr_o.data[data_pos] = sda_io;
					if (bit_q == 3'd0) state_d = ACK1;
					else bit_d = bit_q - 1'b1;
				end
				ACK1: begin
					bit_d = 3'd7;
					if (!rd_q && sda_io) begin
						nack_d  = 1'b1;
						state_d = STOP;
					end else if (cnt_q == '0) begin
						state_d = STOP;
					end else begin
						cnt_d   = cnt_q - 1'b1;
						state_d = rd_q ? RDATA : WDATA;
					end
				end
				STOP: begin
					eng_wr_o.en   = 1'b1;
					eng_wr_o.sel  = `I2C_CFG;
					eng_wr_o.data[CFG_NACK] = nack_q;
					eng_wr_o.data[rd_q ? CFG_RD_DONE : CFG_WR_DONE] = 1'b1;
					state_d       = IDLE;
				end
			endcase
		end
	end

	// SDA level for the low half of the current state.
	always_comb begin
		unique case (state_q)
			START:   sda_nxt = 1'b0;
			ADDR:    sda_nxt = addr_byte[bit_q];
			WDATA:   sda_nxt = eng_rdata_i[data_pos];
			ACK1:    sda_nxt = rd_q ? (cnt_q == '0) : 1'b1; // NACK the last read byte.
			STOP:    sda_nxt = 1'b0;
			default: sda_nxt = 1'b1;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= IDLE;
			bit_q   <= '0;
			cnt_q   <= '0;
			rd_q    <= 1'b0;
			nack_q  <= 1'b0;
			sda_q   <= 1'b1;
		end else begin
			state_q <= state_d;
			bit_q   <= bit_d;
			cnt_q   <= cnt_d;
			rd_q    <= rd_d;
			nack_q  <= nack_d;
			if (phase_i.fall) sda_q <= sda_nxt; // One cycle after SCL falls.
		end
	end

	a_state_on_rise: assert property (@(posedge clk_i) disable iff (rst_i)
		state_q != $past(state_q) |-> $past(phase_i.rise))
		else $error("engine state changed without an SCL rise strobe");

endmodule

`default_nettype wire

//--- i2c_scl_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_settings.svh"

module i2c_scl_gen import i2c_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	output scl_phase_t phase_o
);

	localparam int CNT_W = $clog2(`I2C_HALF_PERIOD);

	logic [CNT_W-1:0] cnt_q;
	logic             wrap;

	assign wrap = (cnt_q == CNT_W'(`I2C_HALF_PERIOD - 1));

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt_q         <= '0;
			phase_o.level <= 1'b1; // Bus idles with SCL high.
			phase_o.rise  <= 1'b0;
			phase_o.fall  <= 1'b0;
		end else begin
			phase_o.rise <= 1'b0;
			phase_o.fall <= 1'b0;
			if (wrap) begin
				cnt_q         <= '0;
				phase_o.level <= ~phase_o.level;
				phase_o.rise  <= ~phase_o.level;
				phase_o.fall  <= phase_o.level;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// Each low half lasts exactly one half period.
	a_half_period: assert property (@(posedge clk_i) disable iff (rst_i)
		phase_o.fall |-> ##`I2C_HALF_PERIOD phase_o.rise)
		else $error("SCL low half has the wrong length");

endmodule

`default_nettype wire

//--- i2c_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_settings.svh"

module i2c_reg_file import i2c_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  host_req_t host_i,
	output word_t     rdata_o,
	input  eng_rd_t   eng_rd_i,
	output word_t     eng_rdata_o,
	input  eng_wr_t   eng_wr_i
);

	localparam int NUM_REGS = (`I2C_CFG >> 2) + 1;
	localparam int RDR_IDX  = `I2C_RDR >> 2;
	localparam int CFG_IDX  = `I2C_CFG >> 2;

	word_t      regs_q [NUM_REGS];
	word_t      regs_d [NUM_REGS];
	logic [2:0] host_idx;
	logic [2:0] eng_idx;

	assign host_idx = host_i.addr[4:2];
	assign eng_idx  = eng_rd_i[4:2];

	// Addresses past CFG read as zero.
	assign eng_rdata_o = (eng_idx < NUM_REGS) ? regs_q[eng_idx] : '0;

	// Host bytes first, then the engine overrides what it owns.
	always_comb begin
		for (int i = 0; i < NUM_REGS; i++) begin
			regs_d[i] = regs_q[i];
			if (host_i.write && host_idx == i) begin
				for (int b = 0; b < 4; b++) begin
					if (host_i.be[b]) begin
						regs_d[i][8*b +: 8] = host_i.wdata[8*b +: 8];
					end
				end
			end
		end

		if (eng_wr_i.en && eng_wr_i.sel == `I2C_RDR) begin
			regs_d[RDR_IDX] = eng_wr_i.data;
		end
		if (eng_wr_i.en && eng_wr_i.sel == `I2C_CFG) begin
			regs_d[CFG_IDX] = (regs_d[CFG_IDX] & ~CFG_ENG_MASK) |
				(eng_wr_i.data & CFG_ENG_MASK);
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else begin
			regs_q <= regs_d;
		end
	end

	// The host sees the value from before any write in the same cycle.
	always_ff @(posedge clk_i) begin
		rdata_o <= (host_idx < NUM_REGS) ? regs_q[host_idx] : '0;
	end

	a_host_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
		host_i.write |-> host_i.addr[1:0] == 2'b00)
		else $error("host write to unaligned address %0h", host_i.addr);

endmodule

`default_nettype wire

//--- i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	typedef logic [31:0] word_t;     // One register value.
	typedef logic [4:0]  reg_addr_t; // Byte address into the register block.
	typedef logic [3:0]  byte_en_t;
	typedef logic [2:0]  byte_cnt_t; // Bytes left in the transfer, minus one.
	typedef logic [2:0]  bit_idx_t;  // Bit position within the current byte.

	// The engine reads one register at a time, selected by its byte address.
	typedef reg_addr_t eng_rd_t;

	typedef struct packed {
		logic      write;
		byte_en_t  be;
		reg_addr_t addr;
		word_t     wdata;
	} host_req_t;

	typedef struct packed {
		logic      en;
		reg_addr_t sel;
		word_t     data;
	} eng_wr_t;

	typedef struct packed {
		logic level; // Free-running bit clock.
		logic rise;  // First cycle of a high half.
		logic fall;  // First cycle of a low half.
	} scl_phase_t;

	typedef enum logic [2:0] {IDLE, START, ADDR, ACK0, WDATA, RDATA, ACK1, STOP} i2c_state_e;

	// CFG register bits.
	localparam int CFG_WR_GO   = 0;
	localparam int CFG_WR_DONE = 1;
	localparam int CFG_RD_GO   = 2;
	localparam int CFG_RD_DONE = 3;
	localparam int CFG_NACK    = 4;

	// CFG bits owned by the engine; everything else belongs to the host.
	localparam word_t CFG_ENG_MASK = word_t'((1 << CFG_WR_DONE) | (1 << CFG_RD_DONE) |
		(1 << CFG_NACK));

endpackage

`default_nettype wire

//--- i2c_settings.svh
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

// Number of clk_i cycles per SCL half period.
// With a 50 MHz system clock this gives a 200 kHz SCL.
`define I2C_HALF_PERIOD 125

// Register byte offsets on the host port.
`define I2C_NBY 5'd0
`define I2C_ADR 5'd4
`define I2C_RDR 5'd8
`define I2C_TDR 5'd12
`define I2C_CFG 5'd16

// Largest transfer in bytes, bounded by the width of RDR and TDR.
`define I2C_MAX_BYTES 4

`endif
